// File: src/bwt_search_defs.svh
`ifndef BWT_SEARCH_DEFS_SVH
`define BWT_SEARCH_DEFS_SVH

// lane and read sizing
`define NUM_LANES    4
`define MAX_READ_LEN 16
`define RD_DEPTH     8

// indexed text, interval bounds up to and including BWT_LEN
`define BWT_LEN      256
`define POS_W        9

`define RD_NUM_W     6
`define LEN_W        5   // holds MAX_READ_LEN itself

`endif

// File: src/bwt_pkg.sv
`include "bwt_search_defs.svh"

package bwt_pkg;

	typedef enum logic [1:0] {A = 2'd0, C = 2'd1, G = 2'd2, T = 2'd3} base_e;

	typedef logic [`POS_W-1:0]             pos_t;      // bound or occurrence count
	typedef logic [`RD_NUM_W-1:0]          read_num_t;
	typedef logic [`LEN_W-1:0]             len_t;
	typedef logic [$clog2(`NUM_LANES)-1:0] lane_idx_t;

	// base i sits at bits [2i+1:2i], first base at the bottom
	typedef struct packed {
		logic [2*`MAX_READ_LEN-1:0] bases;
		len_t                       len;
		read_num_t                  num;
	} read_t;

	typedef enum logic [2:0] {IDLE, REQ_K, REQ_L, UPDATE, DONE} lane_state_e;

	// next requester after last, wrapping
	function automatic lane_idx_t rr_pick(input logic [`NUM_LANES-1:0] req, input lane_idx_t last);
		lane_idx_t pick;
		lane_idx_t cand;
		pick = last;
		for (int i = `NUM_LANES; i >= 1; i--) begin
			cand = lane_idx_t'((int'(last) + i) % `NUM_LANES);
			if (req[cand]) pick = cand;   // nearest one wins, loop runs far to near
		end
		return pick;
	endfunction

endpackage

// File: src/wb_pkg.sv
`include "bwt_search_defs.svh"

package wb_pkg;

	// {base, position} into the occurrence table
	typedef logic [2+`POS_W-1:0] wb_adr_t;

	// count in the low POS_W bits
	typedef logic [31:0] wb_dat_t;

	typedef enum logic {
		ARB_IDLE = 1'b0,
		ARB_BUSY = 1'b1
	} arb_state_e;

endpackage

// File: src/read_dispatcher.sv
`timescale 1ns/1ps
`include "bwt_search_defs.svh"

module read_dispatcher (
	input  logic                              clk_i,
	input  logic                              arst_n_i,
	input  logic                              load_valid_i,
	input  logic [2*`MAX_READ_LEN+`LEN_W-1:0] load_data_i,    // {bases, len}
	output logic                              load_ready_o,
	input  logic [`NUM_LANES-1:0]             lane_idle_i,
	output logic [`NUM_LANES-1:0]             lane_start_o,
	output bwt_pkg::read_t                    lane_read_o
);

	localparam int PTR_W = $clog2(`RD_DEPTH);
	localparam int CNT_W = $clog2(`RD_DEPTH + 1);

	bwt_pkg::read_t         store_q [`RD_DEPTH];
	logic [PTR_W-1:0]       wr_ptr_q;
	logic [PTR_W-1:0]       rd_ptr_q;
	logic [CNT_W-1:0]       count_q;
	bwt_pkg::read_num_t     next_num_q;
	logic                   push;
	logic                   pop;
	logic [`NUM_LANES-1:0]  first_idle;

	// --------------------
	// handshakes
	assign load_ready_o = (count_q != CNT_W'(`RD_DEPTH));
	assign push         = load_valid_i && load_ready_o;
	assign pop          = (count_q != '0) && (|lane_idle_i);

	// lowest idle lane only
	assign first_idle   = lane_idle_i & (~lane_idle_i + 1'b1);
	assign lane_start_o = pop ? first_idle : '0;
	assign lane_read_o  = store_q[rd_ptr_q];

	// --------------------
	// read store
	always_ff @(posedge clk_i) begin
		if (push) begin
			store_q[wr_ptr_q] <= '{
				bases: load_data_i[2*`MAX_READ_LEN+`LEN_W-1:`LEN_W],
				len:   load_data_i[`LEN_W-1:0],
				num:   next_num_q   // stamped in load order
			};
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr_q   <= '0;
			rd_ptr_q   <= '0;
			count_q    <= '0;
			next_num_q <= '0;
		end else begin
			if (push) begin
				if (wr_ptr_q == PTR_W'(`RD_DEPTH - 1)) begin
					wr_ptr_q <= '0;
				end else begin
					wr_ptr_q <= wr_ptr_q + 1'b1;
				end
				next_num_q <= next_num_q + 1'b1;
			end
			if (pop) begin
				if (rd_ptr_q == PTR_W'(`RD_DEPTH - 1)) begin
					rd_ptr_q <= '0;
				end else begin
					rd_ptr_q <= rd_ptr_q + 1'b1;
				end
			end
			case ({push, pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: ;   // both or neither
			endcase
		end
	end

endmodule

// File: src/extend_lane.sv
`timescale 1ns/1ps
`include "bwt_search_defs.svh"

module extend_lane (
	input  logic                    clk_i,
	input  logic                    arst_n_i,
	input  logic                    start_i,
	input  bwt_pkg::read_t          read_i,
	input  bwt_pkg::pos_t [3:0]     c_table_i,
	output logic                    idle_o,
	output logic                    req_o,
	output wb_pkg::wb_adr_t         adr_o,
	input  logic                    gnt_ack_i,
	input  bwt_pkg::pos_t           rdata_i,
	output logic                    done_o,
	input  logic                    pop_i,
	output bwt_pkg::read_num_t      res_read_num_o,
	output bwt_pkg::pos_t           res_k_o,
	output bwt_pkg::pos_t           res_l_o,
	output bwt_pkg::len_t           res_len_o
);

	bwt_pkg::lane_state_e        state_q;
	bwt_pkg::lane_state_e        state_d;
	logic [2*`MAX_READ_LEN-1:0]  bases_q;
	bwt_pkg::len_t               left_q;      // bases still to consume
	bwt_pkg::len_t               matched_q;
	bwt_pkg::read_num_t          num_q;
	bwt_pkg::pos_t               k_q;
	bwt_pkg::pos_t               l_q;
	bwt_pkg::pos_t               occ_k_q;
	bwt_pkg::pos_t               occ_l_q;
	bwt_pkg::len_t               base_idx;
	bwt_pkg::base_e              cur_base;
	bwt_pkg::pos_t               new_k;
	bwt_pkg::pos_t               new_l;
	logic                        hit;

	// walks from the last base toward the first
	assign base_idx = left_q - 1'b1;
	assign cur_base = bwt_pkg::base_e'(bases_q[2*base_idx +: 2]);

	// --------------------
	// interval update
	assign new_k = c_table_i[cur_base] + occ_k_q;
	assign new_l = c_table_i[cur_base] + occ_l_q;
	assign hit   = (new_k < new_l);   // empty interval ends the search

	assign idle_o = (state_q == bwt_pkg::IDLE);
	assign req_o  = (state_q == bwt_pkg::REQ_K) || (state_q == bwt_pkg::REQ_L);
	assign adr_o  = {cur_base, (state_q == bwt_pkg::REQ_L) ? l_q : k_q};
	assign done_o = (state_q == bwt_pkg::DONE);

	assign res_read_num_o = num_q;
	assign res_k_o        = k_q;   // last non-empty interval
	assign res_l_o        = l_q;
	assign res_len_o      = matched_q;

	// --------------------
	// state machine
	always_comb begin
		state_d = state_q;
		case (state_q)
			bwt_pkg::IDLE:   if (start_i) state_d = (read_i.len == '0) ? bwt_pkg::DONE : bwt_pkg::REQ_K;
			bwt_pkg::REQ_K:  if (gnt_ack_i) state_d = bwt_pkg::REQ_L;
			bwt_pkg::REQ_L:  if (gnt_ack_i) state_d = bwt_pkg::UPDATE;
			bwt_pkg::UPDATE: begin
				if (!hit || left_q == bwt_pkg::len_t'(1)) begin
					state_d = bwt_pkg::DONE;
				end else begin
					state_d = bwt_pkg::REQ_K;
				end
			end
			bwt_pkg::DONE:   if (pop_i) state_d = bwt_pkg::IDLE;   // held until collected
			default:         state_d = bwt_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= bwt_pkg::IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_ff @(posedge clk_i) begin
		case (state_q)
			bwt_pkg::IDLE: begin
				if (start_i) begin
					bases_q   <= read_i.bases;
					left_q    <= read_i.len;
					num_q     <= read_i.num;
					k_q       <= '0;
					l_q       <= bwt_pkg::pos_t'(`BWT_LEN);
					matched_q <= '0;
				end
			end
			bwt_pkg::REQ_K:  if (gnt_ack_i) occ_k_q <= rdata_i;
			bwt_pkg::REQ_L:  if (gnt_ack_i) occ_l_q <= rdata_i;
			bwt_pkg::UPDATE: begin
				if (hit) begin
					k_q       <= new_k;
					l_q       <= new_l;
					matched_q <= matched_q + 1'b1;
					left_q    <= left_q - 1'b1;
				end
			end
			default: ;
		endcase
	end

endmodule

// File: src/occ_arbiter.sv
`timescale 1ns/1ps
`include "bwt_search_defs.svh"

module occ_arbiter (
	input  logic                                 clk_i,
	input  logic                                 arst_n_i,
	input  logic [`NUM_LANES-1:0]                lane_req_i,
	input  wb_pkg::wb_adr_t [`NUM_LANES-1:0]     lane_adr_i,
	output logic [`NUM_LANES-1:0]                lane_gnt_ack_o,
	output bwt_pkg::pos_t                        lane_rdata_o,
	output logic                                 wb_cyc_o,
	output logic                                 wb_stb_o,
	output wb_pkg::wb_adr_t                      wb_adr_o,
	input  wb_pkg::wb_dat_t                      wb_dat_i,
	input  logic                                 wb_ack_i
);

	wb_pkg::arb_state_e   state_q;
	bwt_pkg::lane_idx_t   owner_q;   // also the round-robin pointer
	bwt_pkg::lane_idx_t   pick;
	wb_pkg::wb_adr_t      adr_q;

	assign pick = bwt_pkg::rr_pick(lane_req_i, owner_q);

	// one classic cycle at a time, cyc and stb move together
	assign wb_cyc_o = (state_q == wb_pkg::ARB_BUSY);
	assign wb_stb_o = (state_q == wb_pkg::ARB_BUSY);
	assign wb_adr_o = adr_q;

	// grant pulse lands on the ack cycle
	assign lane_gnt_ack_o = (state_q == wb_pkg::ARB_BUSY && wb_ack_i) ?
		(`NUM_LANES'(1) << owner_q) : '0;
	assign lane_rdata_o = wb_dat_i[`POS_W-1:0];

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= wb_pkg::ARB_IDLE;
			owner_q <= bwt_pkg::lane_idx_t'(`NUM_LANES - 1);   // lane 0 goes first
		end else begin
			case (state_q)
				wb_pkg::ARB_IDLE: begin
					if (|lane_req_i) begin
						state_q <= wb_pkg::ARB_BUSY;
						owner_q <= pick;
					end
				end
				wb_pkg::ARB_BUSY: if (wb_ack_i) state_q <= wb_pkg::ARB_IDLE;
				default: state_q <= wb_pkg::ARB_IDLE;
			endcase
		end
	end

	// address held for the whole cycle
	always_ff @(posedge clk_i) begin
		if (state_q == wb_pkg::ARB_IDLE && (|lane_req_i)) begin
			adr_q <= lane_adr_i[pick];
		end
	end

endmodule

// File: src/result_collector.sv
`timescale 1ns/1ps
`include "bwt_search_defs.svh"

module result_collector (
	input  logic                                  clk_i,
	input  logic                                  arst_n_i,
	input  logic [`NUM_LANES-1:0]                 lane_done_i,
	input  bwt_pkg::read_num_t [`NUM_LANES-1:0]   lane_read_num_i,
	input  bwt_pkg::pos_t [`NUM_LANES-1:0]        lane_k_i,
	input  bwt_pkg::pos_t [`NUM_LANES-1:0]        lane_l_i,
	input  bwt_pkg::len_t [`NUM_LANES-1:0]        lane_len_i,
	output logic [`NUM_LANES-1:0]                 lane_pop_o,
	output logic                                  result_valid_o,
	output bwt_pkg::read_num_t                    result_read_num_o,
	output bwt_pkg::pos_t                         result_k_o,
	output bwt_pkg::pos_t                         result_l_o,
	output bwt_pkg::len_t                         result_len_o,
	input  logic                                  result_ready_i
);

	logic                 valid_q;
	logic                 can_load;
	logic                 load;
	bwt_pkg::lane_idx_t   last_q;
	bwt_pkg::lane_idx_t   pick;

	// register empty or draining this cycle
	assign can_load = !valid_q || result_ready_i;
	assign load     = can_load && (|lane_done_i);
	assign pick     = bwt_pkg::rr_pick(lane_done_i, last_q);

	assign lane_pop_o     = load ? (`NUM_LANES'(1) << pick) : '0;
	assign result_valid_o = valid_q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q <= 1'b0;
			last_q  <= bwt_pkg::lane_idx_t'(`NUM_LANES - 1);
		end else begin
			if (can_load) valid_q <= |lane_done_i;
			if (load) last_q <= pick;
		end
	end

	// output data, frozen while stalled
	always_ff @(posedge clk_i) begin
		if (load) begin
			result_read_num_o <= lane_read_num_i[pick];
			result_k_o        <= lane_k_i[pick];
			result_l_o        <= lane_l_i[pick];
			result_len_o      <= lane_len_i[pick];
		end
	end

endmodule

// File: src/bwt_search_top.sv
`timescale 1ns/1ps
`include "bwt_search_defs.svh"

module bwt_search_top (
	input  logic                              clk_i,
	input  logic                              arst_n_i,
	input  logic                              load_valid_i,
	input  logic [2*`MAX_READ_LEN+`LEN_W-1:0] load_data_i,
	output logic                              load_ready_o,
	input  bwt_pkg::pos_t [3:0]               c_table_i,
	output logic                              wb_cyc_o,
	output logic                              wb_stb_o,
	output logic                              wb_we_o,
	output wb_pkg::wb_adr_t                   wb_adr_o,
	input  wb_pkg::wb_dat_t                   wb_dat_i,
	input  logic                              wb_ack_i,
	output logic                              result_valid_o,
	output bwt_pkg::read_num_t                result_read_num_o,
	output bwt_pkg::pos_t                     result_k_o,
	output bwt_pkg::pos_t                     result_l_o,
	output bwt_pkg::len_t                     result_len_o,
	input  logic                              result_ready_i
);

	// --------------------
	// lane side wiring
	logic [`NUM_LANES-1:0]                 lane_idle;
	logic [`NUM_LANES-1:0]                 lane_start;
	bwt_pkg::read_t                        lane_read;
	logic [`NUM_LANES-1:0]                 lane_req;
	wb_pkg::wb_adr_t [`NUM_LANES-1:0]      lane_adr;
	logic [`NUM_LANES-1:0]                 lane_gnt_ack;
	bwt_pkg::pos_t                         lane_rdata;   // shared, qualified by grant
	logic [`NUM_LANES-1:0]                 lane_done;
	logic [`NUM_LANES-1:0]                 lane_pop;
	bwt_pkg::read_num_t [`NUM_LANES-1:0]   lane_read_num;
	bwt_pkg::pos_t [`NUM_LANES-1:0]        lane_k;
	bwt_pkg::pos_t [`NUM_LANES-1:0]        lane_l;
	bwt_pkg::len_t [`NUM_LANES-1:0]        lane_len;

	assign wb_we_o = 1'b0;   // read-only index

	read_dispatcher u_dispatch (
		.clk_i        (clk_i),
		.arst_n_i     (arst_n_i),
		.load_valid_i (load_valid_i),
		.load_data_i  (load_data_i),
		.load_ready_o (load_ready_o),
		.lane_idle_i  (lane_idle),
		.lane_start_o (lane_start),
		.lane_read_o  (lane_read)
	);

	for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
		extend_lane u_lane (
			.clk_i          (clk_i),
			.arst_n_i       (arst_n_i),
			.start_i        (lane_start[i]),
			.read_i         (lane_read),
			.c_table_i      (c_table_i),
			.idle_o         (lane_idle[i]),
			.req_o          (lane_req[i]),
			.adr_o          (lane_adr[i]),
			.gnt_ack_i      (lane_gnt_ack[i]),
			.rdata_i        (lane_rdata),
			.done_o         (lane_done[i]),
			.pop_i          (lane_pop[i]),
			.res_read_num_o (lane_read_num[i]),
			.res_k_o        (lane_k[i]),
			.res_l_o        (lane_l[i]),
			.res_len_o      (lane_len[i])
		);
	end

	occ_arbiter u_arb (
		.clk_i          (clk_i),
		.arst_n_i       (arst_n_i),
		.lane_req_i     (lane_req),
		.lane_adr_i     (lane_adr),
		.lane_gnt_ack_o (lane_gnt_ack),
		.lane_rdata_o   (lane_rdata),
		.wb_cyc_o       (wb_cyc_o),
		.wb_stb_o       (wb_stb_o),
		.wb_adr_o       (wb_adr_o),
		.wb_dat_i       (wb_dat_i),
		.wb_ack_i       (wb_ack_i)
	);

	result_collector u_collect (
		.clk_i             (clk_i),
		.arst_n_i          (arst_n_i),
		.lane_done_i       (lane_done),
		.lane_read_num_i   (lane_read_num),
		.lane_k_i          (lane_k),
		.lane_l_i          (lane_l),
		.lane_len_i        (lane_len),
		.lane_pop_o        (lane_pop),
		.result_valid_o    (result_valid_o),
		.result_read_num_o (result_read_num_o),
		.result_k_o        (result_k_o),
		.result_l_o        (result_l_o),
		.result_len_o      (result_len_o),
		.result_ready_i    (result_ready_i)
	);

endmodule

// File: sim/occ_mem_model.sv
`timescale 1ns/1ps
`include "bwt_search_defs.svh"

module occ_mem_model #(
	parameter logic [31:0] SEED = 32'h9805_cbae
) (
	input  logic            clk_i,
	input  logic            arst_n_i,
	input  logic            cyc_i,
	input  logic            stb_i,
	input  wb_pkg::wb_adr_t adr_i,
	output wb_pkg::wb_dat_t dat_o,
	output logic            ack_o
);

	localparam int WORDS = 1 << $bits(wb_pkg::wb_adr_t);

	wb_pkg::wb_dat_t mem [WORDS];
	integer          seed = SEED;
	logic            active_q;    // wait already drawn for this access
	logic [1:0]      wait_q;
	logic [1:0]      draw;

	// address copied into both halves, positions past BWT_LEN keep it
	initial begin
		for (int a = 0; a < WORDS; a++) begin
			mem[a] = wb_pkg::wb_dat_t'(a) * 32'h0001_0001;
		end
	end

	task automatic write_word(input wb_pkg::wb_adr_t adr, input wb_pkg::wb_dat_t dat);
		mem[adr] = dat;
	endtask

	// classic slave, ack after 0 to 3 extra wait cycles
	always @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_o    <= 1'b0;
			dat_o    <= '0;
			active_q <= 1'b0;
			wait_q   <= '0;
		end else begin
			ack_o <= 1'b0;   // single cycle pulse
			if (cyc_i && stb_i && !ack_o) begin
				if (!active_q) begin
					draw = 2'($random(seed));
					if (draw == 2'd0) begin
						ack_o <= 1'b1;
						dat_o <= mem[adr_i];
					end else begin
						active_q <= 1'b1;
						wait_q   <= draw - 1'b1;
					end
				end else if (wait_q == 2'd0) begin
					ack_o    <= 1'b1;
					dat_o    <= mem[adr_i];
					active_q <= 1'b0;
				end else begin
					wait_q <= wait_q - 1'b1;
				end
			end
		end
	end

endmodule

// File: sim/bwt_search_properties.sv
`timescale 1ns/1ps
`include "bwt_search_defs.svh"

module bwt_search_properties #(
	parameter int ADR_W = 2 + `POS_W,
	parameter int RES_W = `RD_NUM_W + 2 * `POS_W + `LEN_W
) (
	input logic                  clk_i,
	input logic                  arst_n_i,
	input logic                  cyc_i,
	input logic                  stb_i,
	input logic [ADR_W-1:0]      adr_i,
	input logic                  ack_i,
	input logic [`NUM_LANES-1:0] gnt_i,
	input logic                  res_valid_i,
	input logic                  res_ready_i,
	input logic [RES_W-1:0]      res_data_i
);

	int unsigned fail_cnt = 0;   // read by the testbench

	// --------------------
	// wishbone side
	stb_needs_cyc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		stb_i |-> cyc_i)
		else begin fail_cnt++; $error("wb_stb_o high without wb_cyc_o"); end

	stb_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(stb_i && !ack_i) |=> (stb_i && $stable(adr_i)))
		else begin fail_cnt++; $error("wb_stb_o or wb_adr_o moved before ack"); end

	gnt_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		$onehot0(gnt_i))
		else begin fail_cnt++; $error("more than one lane granted"); end

	// --------------------
	// result side
	res_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(res_valid_i && !res_ready_i) |=> (res_valid_i && $stable(res_data_i)))
		else begin fail_cnt++; $error("stalled result changed or dropped"); end

endmodule

bind occ_arbiter bwt_search_properties u_bus_props (
	.clk_i       (clk_i),
	.arst_n_i    (arst_n_i),
	.cyc_i       (wb_cyc_o),
	.stb_i       (wb_stb_o),
	.adr_i       (wb_adr_o),
	.ack_i       (wb_ack_i),
	.gnt_i       (lane_gnt_ack_o),
	.res_valid_i (1'b0),
	.res_ready_i (1'b1),
	.res_data_i  ('0)
);

bind result_collector bwt_search_properties u_res_props (
	.clk_i       (clk_i),
	.arst_n_i    (arst_n_i),
	.cyc_i       (1'b0),
	.stb_i       (1'b0),
	.adr_i       ('0),
	.ack_i       (1'b0),
	.gnt_i       ('0),
	.res_valid_i (result_valid_o),
	.res_ready_i (result_ready_i),
	.res_data_i  ({result_read_num_o, result_k_o, result_l_o, result_len_o})
);

// File: sim/tb_bwt_search.sv
`timescale 1ns/1ps
`include "bwt_search_defs.svh"

module tb_bwt_search;

	localparam int TOTAL_READS = 1 + 40 + 16 + 40 + 40;
	localparam int HOLD_CYCLES = 300;
	// six cycles per access and two accesses per base with twice the margin
	localparam int MAX_CYCLES  = TOTAL_READS * 2 * `MAX_READ_LEN * 6 * 2 + HOLD_CYCLES;
	localparam int BASES_W     = 2 * `MAX_READ_LEN;
	localparam int NUM_IDS     = 1 << `RD_NUM_W;
	localparam int READY_ON    = 0;
	localparam int READY_RAND  = 1;
	localparam int READY_OFF   = 2;

	logic                              clk = 1'b0;
	logic                              arst_n;
	logic                              load_valid;
	logic [BASES_W+`LEN_W-1:0]         load_data;
	logic                              load_ready;
	bwt_pkg::pos_t [3:0]               c_table;
	logic                              wb_cyc;
	logic                              wb_stb;
	logic                              wb_we;
	wb_pkg::wb_adr_t                   wb_adr;
	wb_pkg::wb_dat_t                   wb_dat;
	logic                              wb_ack;
	logic                              res_valid;
	bwt_pkg::read_num_t                res_num;
	bwt_pkg::pos_t                     res_k;
	bwt_pkg::pos_t                     res_l;
	bwt_pkg::len_t                     res_len;
	logic                              res_ready;
	logic                              ready_next;

	integer             seed = 32'h9805_cbae;
	bwt_pkg::base_e     bwt_str [`BWT_LEN];
	bwt_pkg::pos_t      occ_tab [4][`BWT_LEN+1];
	bwt_pkg::pos_t      c_tab   [4];
	logic               pending [NUM_IDS];   // indexed by read number
	bwt_pkg::pos_t      exp_k   [NUM_IDS];
	bwt_pkg::pos_t      exp_l   [NUM_IDS];
	bwt_pkg::len_t      exp_len [NUM_IDS];
	bwt_pkg::len_t      rd_len  [NUM_IDS];
	bwt_pkg::read_num_t next_num;
	bwt_pkg::read_num_t held_num;
	bwt_pkg::pos_t      held_k;
	bwt_pkg::pos_t      held_l;
	bwt_pkg::len_t      held_len;
	logic               held;
	logic               saw_full;
	int                 outstanding;
	int                 early_cnt;
	int                 stall_cnt;
	int                 ready_mode;
	int                 cycles;

	bwt_search_top dut0 (
		.clk_i             (clk),
		.arst_n_i          (arst_n),
		.load_valid_i      (load_valid),
		.load_data_i       (load_data),
		.load_ready_o      (load_ready),
		.c_table_i         (c_table),
		.wb_cyc_o          (wb_cyc),
		.wb_stb_o          (wb_stb),
		.wb_we_o           (wb_we),
		.wb_adr_o          (wb_adr),
		.wb_dat_i          (wb_dat),
		.wb_ack_i          (wb_ack),
		.result_valid_o    (res_valid),
		.result_read_num_o (res_num),
		.result_k_o        (res_k),
		.result_l_o        (res_l),
		.result_len_o      (res_len),
		.result_ready_i    (res_ready)
	);

	occ_mem_model #(.SEED(32'h9805_cbae)) mem0 (
		.clk_i    (clk),
		.arst_n_i (arst_n),
		.cyc_i    (wb_cyc),
		.stb_i    (wb_stb),
		.adr_i    (wb_adr),
		.dat_o    (wb_dat),
		.ack_o    (wb_ack)
	);

	always #4 clk = ~clk;

	// --------------------
	// failure reporting
	task automatic stop_run();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic fail_run(input string why);
		$display("%s", why);
		stop_run();
	endtask

	task automatic check_pos(input string name, input bwt_pkg::pos_t got,
		input bwt_pkg::pos_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_len(input string name, input bwt_pkg::len_t got,
		input bwt_pkg::len_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_num(input string name, input bwt_pkg::read_num_t got,
		input bwt_pkg::read_num_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
			stop_run();
		end
	endtask

	// --------------------
	// index and reference search
	task automatic build_index();
		bwt_pkg::pos_t total;
		for (int p = 0; p < `BWT_LEN; p++) begin
			bwt_str[p] = bwt_pkg::base_e'(2'($random(seed)));
		end
		for (int c = 0; c < 4; c++) begin
			occ_tab[c][0] = '0;   // Occ(c,p) counts c in bwt_str[0..p-1]
			for (int p = 0; p < `BWT_LEN; p++) begin
				occ_tab[c][p+1] = occ_tab[c][p] + ((int'(bwt_str[p]) == c) ? 1'b1 : 1'b0);
			end
		end
		total = '0;
		for (int c = 0; c < 4; c++) begin
			c_tab[c]   = total;   // bases smaller than c
			c_table[c] = total;
			total      = total + occ_tab[c][`BWT_LEN];
		end
	endtask

	task automatic fill_occ_mem();
		for (int c = 0; c < 4; c++) begin
			for (int p = 0; p <= `BWT_LEN; p++) begin
				mem0.write_word({2'(c), `POS_W'(p)}, wb_pkg::wb_dat_t'(occ_tab[c][p]));
			end
		end
	endtask

	task automatic search_model(input logic [BASES_W-1:0] bases, input bwt_pkg::len_t len,
		output bwt_pkg::pos_t k, output bwt_pkg::pos_t l, output bwt_pkg::len_t m);
		bwt_pkg::base_e c;
		bwt_pkg::pos_t  nk;
		bwt_pkg::pos_t  nl;
		k = '0;
		l = bwt_pkg::pos_t'(`BWT_LEN);
		m = '0;
		for (int i = int'(len) - 1; i >= 0; i--) begin   // last base first
			c  = bwt_pkg::base_e'(bases[2*i +: 2]);
			nk = c_tab[c] + occ_tab[c][k];
			nl = c_tab[c] + occ_tab[c][l];
			if (nk >= nl) break;   // empty interval keeps the previous one
			k = nk;
			l = nl;
			m = m + 1'b1;
		end
	endtask

	function automatic bwt_pkg::len_t random_len();
		return bwt_pkg::len_t'(1 + $unsigned($random(seed)) % `MAX_READ_LEN);
	endfunction

	// --------------------
	// stimulus tasks start 1 ns after a rising edge
	task automatic load_read(input bwt_pkg::len_t len);
		logic [BASES_W-1:0] bases;
		logic               taken;
		bases      = BASES_W'($random(seed));
		load_data  = {bases, len};
		load_valid = 1'b1;
		taken      = 1'b0;
		while (!taken) begin
			taken = load_ready;   // only moves on clock edges
			@(posedge clk);
			#1;
		end
		search_model(bases, len, exp_k[next_num], exp_l[next_num], exp_len[next_num]);
		rd_len[next_num]  = len;
		pending[next_num] = 1'b1;
		outstanding       = outstanding + 1;
		next_num          = next_num + 1'b1;
		load_valid        = 1'b0;
	endtask

	task automatic drain();
		while (outstanding != 0) begin
			@(posedge clk);
		end
		#1;
	endtask

	// ready value drawn at the edge and driven 1 ns later
	always @(posedge clk) begin
		case (ready_mode)
			READY_ON:   ready_next = 1'b1;
			READY_RAND: ready_next = 1'($random(seed));   // about half the cycles
			default:    ready_next = 1'b0;
		endcase
		#1;
		res_ready = ready_next;
	end

	// --------------------
	// result monitor at mid cycle
	task automatic take_result();
		bwt_pkg::read_num_t num;
		num = res_num;
		if (!pending[num]) begin
			fail_run($sformatf("result for read %0d came with no such read outstanding", num));
		end else begin
			check_pos("result_k_o", res_k, exp_k[num]);
			check_pos("result_l_o", res_l, exp_l[num]);
			check_len("result_len_o", res_len, exp_len[num]);
			if (res_len < rd_len[num]) early_cnt = early_cnt + 1;
			pending[num] = 1'b0;
			outstanding  = outstanding - 1;
		end
	endtask

	always @(negedge clk) begin
		if (arst_n) begin
			if (dut0.u_arb.u_bus_props.fail_cnt != 0 ||
				dut0.u_collect.u_res_props.fail_cnt != 0) begin
				fail_run("a bus or result handshake assertion failed");
			end
			if (wb_we) fail_run("write cycle seen on the index bus");
			if (held) begin
				if (!res_valid) fail_run("result_valid_o dropped while the result was held");
				check_num("result_read_num_o", res_num, held_num);
				check_pos("result_k_o", res_k, held_k);
				check_pos("result_l_o", res_l, held_l);
				check_len("result_len_o", res_len, held_len);
			end
			if (res_valid && res_ready) take_result();
			held = res_valid && !res_ready;
			if (held) begin
				held_num  = res_num;
				held_k    = res_k;
				held_l    = res_l;
				held_len  = res_len;
				stall_cnt = stall_cnt + 1;
			end
			if (load_valid && !load_ready) saw_full = 1'b1;
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles == MAX_CYCLES) begin
			fail_run($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
		end
	end

	// --------------------
	// test sequence
	initial begin
		arst_n      = 1'b0;
		load_valid  = 1'b0;
		load_data   = '0;
		c_table     = '0;
		res_ready   = 1'b0;
		ready_mode  = READY_ON;
		next_num    = '0;
		held        = 1'b0;
		saw_full    = 1'b0;
		outstanding = 0;
		early_cnt   = 0;
		stall_cnt   = 0;
		cycles      = 0;
		for (int i = 0; i < NUM_IDS; i++) begin
			pending[i] = 1'b0;
		end
		build_index();
		@(posedge clk);
		fill_occ_mem();   // after the model's own fill
		repeat (9) @(posedge clk);
		#1;
		arst_n = 1'b1;

		load_read(bwt_pkg::len_t'(1));   // single base
		drain();

		repeat (40) load_read(random_len());
		drain();

		early_cnt = 0;
		repeat (16) load_read(bwt_pkg::len_t'(`MAX_READ_LEN));
		drain();
		if (early_cnt == 0) fail_run("no full-length read ended early");

		ready_mode = READY_RAND;
		stall_cnt  = 0;
		repeat (40) load_read(random_len());
		drain();
		if (stall_cnt == 0) fail_run("random ready never stalled a result");

		// results blocked until the store backs up
		saw_full   = 1'b0;
		ready_mode = READY_OFF;
		fork
			repeat (40) load_read(random_len());
			begin
				repeat (HOLD_CYCLES) @(posedge clk);
				#1;
				ready_mode = READY_ON;
			end
		join
		drain();

		if (!saw_full) begin
			fail_run("load_ready_o never dropped while results were blocked");
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

// File: bwt_search.f
+incdir+src
src/bwt_pkg.sv
src/wb_pkg.sv
src/read_dispatcher.sv
src/extend_lane.sv
src/occ_arbiter.sv
src/result_collector.sv
src/bwt_search_top.sv
sim/occ_mem_model.sv
sim/bwt_search_properties.sv
sim/tb_bwt_search.sv

// File: Makefile
TOP := tb_bwt_search

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f bwt_search.f --top-module $(TOP)

# exit status comes from the search for the pass line
sim:
	verilator --binary --assert -Wno-fatal -f bwt_search.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
